/* build.f */
hw/firPkg.sv
hw/tapIf.sv
hw/tapLoader.sv
hw/sampleLine.sv
hw/macEngine.sv
hw/firFilter.sv
sim/firFilter_chk.sv
sim/firFilterTb.sv

/* hw/firFilter.sv */
/*
 * FIR filter top level. Connects the coefficient loader, the sample
 * delay line and the multiply-accumulate engine over one tap bus.
 */
module firFilter (
	input logic clock,
	input logic rst,
	input logic coefficientStrobe,
	input firPkg::coeffWord coefficientIn,
	input logic dataStrobe,
	input firPkg::sampleWord dataIn,
	input logic stop,
	output firPkg::accWord dataOut,
	output logic outValid,
	output logic busy,
	output logic coefficientsReady
);

	// Tap bus shared by the three blocks.
	tapIf taps ();

	// Coefficient bank, filled once after reset.
	tapLoader i_tapLoader (
		.clock(clock),
		.rst(rst),
		.coefficientStrobe(coefficientStrobe),
		.coefficientIn(coefficientIn),
		.taps(taps.loader)
	);

	// Delay line of the most recent samples.
	sampleLine i_sampleLine (
		.clock(clock),
		.rst(rst),
		.taps(taps.line)
	);

	// Engine that walks the taps and forms each output.
	macEngine i_macEngine (
		.clock(clock),
		.rst(rst),
		.dataStrobe(dataStrobe),
		.dataIn(dataIn),
		.stop(stop),
		.dataOut(dataOut),
		.outValid(outValid),
		.busy(busy),
		.taps(taps.mac)
	);

	// The loader's ready flag is also visible outside.
	assign coefficientsReady = taps.coefficientsReady;

endmodule

/* hw/firPkg.sv */
/*
 * FIR filter package with the filter length, the word widths, the word
 * typedefs and the state encoding of the multiply-accumulate engine.
 */
package firPkg;

	// Number of taps in the filter.
	localparam int NumTaps = 8;

	// Input sample and coefficient widths, both two's complement.
	localparam int SampleWidth = 8;
	localparam int CoeffWidth = 8;

	// A sum of eight full-scale products needs three bits beyond one product.
	localparam int AccWidth = SampleWidth + CoeffWidth + $clog2(NumTaps);

	// Word types for the data path.
	typedef logic signed [SampleWidth-1:0] sampleWord;
	typedef logic signed [CoeffWidth-1:0] coeffWord;
	typedef logic signed [AccWidth-1:0] accWord;

	// Index of one tap, shared by the coefficient bank and the delay line.
	typedef logic [$clog2(NumTaps)-1:0] tapAddr;

	// Engine states; macStop is only left through reset.
	typedef enum logic [1:0] {
		macIdle,
		macAccumulate,
		macStop
	} macState;

endpackage

/* hw/macEngine.sv */
/*
 * Multiply-accumulate engine. Accepts one sample at a time, sums one tap
 * product per cycle and publishes each result with a one-cycle valid pulse.
 */
module macEngine (
	input logic clock,
	input logic rst,
	input logic dataStrobe,
	input firPkg::sampleWord dataIn,
	input logic stop,
	output firPkg::accWord dataOut,
	output logic outValid,
	output logic busy,
	tapIf.mac taps
);
	import firPkg::*;

	macState state;
	tapAddr tapIndex;
	logic shiftPulse;
	sampleWord heldSample;
	logic sumDone;
	logic stopSeen;
	accWord acc;
	accWord product;
	logic accept;
	logic summing;
	logic publish;

	// A strobe is taken only when idle, loaded and not being stopped.
	assign accept = (state == macIdle) && !stop && dataStrobe && taps.coefficientsReady;

	// The first cycle of a run is spent shifting the sample in.
	// The next NumTaps cycles each add one tap product.
	assign summing = (state == macAccumulate) && !shiftPulse && !sumDone;

	// Final cycle of a run, after the last tap has been added.
	assign publish = (state == macAccumulate) && sumDone;

	// Product of the addressed tap, sign extended to the accumulator width.
	assign product = taps.coefficient * taps.sample;

	assign busy = (state == macAccumulate);

	assign taps.tapIndex = tapIndex;
	assign taps.shift = shiftPulse;
	assign taps.newSample = heldSample;

	// Control path.
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= macIdle;
			tapIndex <= '0;
			shiftPulse <= 1'b0;
			sumDone <= 1'b0;
			stopSeen <= 1'b0;
			outValid <= 1'b0;
			dataOut <= '0;
		end else begin
			shiftPulse <= 1'b0;
			outValid <= 1'b0;
			case (state)
				macIdle: begin
					// Stop wins over a strobe in the same cycle.
					if (stop) begin
						state <= macStop;
					end else if (accept) begin
						state <= macAccumulate;
						shiftPulse <= 1'b1;
						tapIndex <= '0;
						sumDone <= 1'b0;
						stopSeen <= 1'b0;
					end
				end
				macAccumulate: begin
					// A stop during a run is held until the result is out.
					if (stop) begin
						stopSeen <= 1'b1;
					end
					if (summing) begin
						if (tapIndex == tapAddr'(NumTaps - 1)) begin
							sumDone <= 1'b1;
						end else begin
							tapIndex <= tapIndex + tapAddr'(1);
						end
					end
					if (publish) begin
						dataOut <= acc;
						outValid <= 1'b1;
						state <= (stopSeen || stop) ? macStop : macIdle;
					end
				end
				macStop: begin
					state <= macStop;
				end
				default: begin
					state <= macIdle;
				end
			endcase
		end
	end

	// Data path. The sample is held for the shift, and the sum restarts
	// from zero with every accepted strobe.
	always_ff @(posedge clock) begin
		if (accept) begin
			heldSample <= dataIn;
			acc <= '0;
		end else if (summing) begin
			acc <= acc + product;
		end
	end

endmodule

/* hw/sampleLine.sv */
/*
 * Sample delay line. A shift strobe ages every sample by one position and
 * writes the new sample at position 0; the tap index selects the age.
 */
module sampleLine (
	input logic clock,
	input logic rst,
	tapIf.line taps
);
	import firPkg::*;

	// Position k holds the sample k steps older than the newest one.
	sampleWord sampleBank [NumTaps];

	// Samples before the first accepted one count as zero, which the
	// cleared bank gives for free.
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < NumTaps; i++) begin
				sampleBank[i] <= '0;
			end
		end else if (taps.shift) begin
			sampleBank[0] <= taps.newSample;
			for (int i = 1; i < NumTaps; i++) begin
				sampleBank[i] <= sampleBank[i-1];
			end
		end
	end

	// Combinational read.
	// The engine steps the index one tap per cycle.
	assign taps.sample = sampleBank[taps.tapIndex];

endmodule

/* hw/tapIf.sv */
/*
 * Tap bus between the engine, the coefficient bank and the delay line.
 */
interface tapIf;
	import firPkg::*;

	// Driven by the engine.
	tapAddr tapIndex;
	logic shift;
	sampleWord newSample;

	// Driven by the coefficient loader.
	coeffWord coefficient;
	logic coefficientsReady;

	// Driven by the delay line.
	sampleWord sample;

	// Coefficient bank reads the index and answers with h[tapIndex].
	modport loader(input tapIndex, output coefficient, output coefficientsReady);

	// Delay line takes shift strobes and answers with x[t - tapIndex].
	modport line(input tapIndex, input shift, input newSample, output sample);

	// The engine steers both stores.
	modport mac(
		output tapIndex,
		output shift,
		output newSample,
		input coefficient,
		input coefficientsReady,
		input sample
	);

endinterface

/* hw/tapLoader.sv */
/*
 * Coefficient loader. Shifts in one coefficient per strobe until the bank
 * is full, then raises the ready flag and serves h[k] for tap index k.
 */
module tapLoader (
	input logic clock,
	input logic rst,
	input logic coefficientStrobe,
	input firPkg::coeffWord coefficientIn,
	tapIf.loader taps
);
	import firPkg::*;

	// Counter type wide enough to hold the value NumTaps itself.
	typedef logic [$clog2(NumTaps + 1)-1:0] countWord;

	coeffWord coeffBank [NumTaps];
	countWord loadCount;
	logic bankFull;
	tapAddr bankIndex;

	// The bank is full once every tap has received its coefficient.
	assign bankFull = (loadCount == countWord'(NumTaps));

	// New coefficients enter at position 0 and move up on every strobe.
	// Strobes after the bank is full are ignored, so the set stays fixed
	// until the next reset.
	always_ff @(posedge clock) begin
		if (rst) begin
			loadCount <= '0;
			for (int i = 0; i < NumTaps; i++) begin
				coeffBank[i] <= '0;
			end
		end else if (coefficientStrobe && !bankFull) begin
			coeffBank[0] <= coefficientIn;
			for (int i = 1; i < NumTaps; i++) begin
				coeffBank[i] <= coeffBank[i-1];
			end
			loadCount <= loadCount + countWord'(1);
		end
	end

	// The first coefficient loaded ends up at the far end of the bank.
	// Reading from the far end gives h[k] for tap index k.
	assign bankIndex = tapAddr'(NumTaps - 1) - taps.tapIndex;

	assign taps.coefficient = coeffBank[bankIndex];
	assign taps.coefficientsReady = bankFull;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the FIR filter testbench with Verilator and runs it.
# The exit status is non-zero when the build fails, the simulation aborts,
# or the log holds the fail message.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
	--top-module firFilterTb -o firFilterTb

./obj_dir/firFilterTb 2>&1 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
	exit 1
fi
exit 0

/* sim/firFilterTb.sv */
/*
 * FIR filter testbench. Applies a table of coefficient, sample, stop and
 * reset rows and checks every result against a software model of the filter.
 */
module firFilterTb;
	import firPkg::*;

	// Operations that a table row can ask for.
	typedef enum int {
		opCoeff,
		opSample,
		opDouble,
		opStop,
		opReset,
		opWait
	} rowOp;

	logic clock;
	logic rst;
	logic coefficientStrobe;
	coeffWord coefficientIn;
	logic dataStrobe;
	sampleWord dataIn;
	logic stop;
	accWord dataOut;
	logic outValid;
	logic busy;
	logic coefficientsReady;

	// Stimulus table. Row r is spread over the four queues.
	rowOp rowOps[$];
	int rowValues[$];
	bit rowExpects[$];
	string rowNames[$];

	// Model state. History entry k is the sample k steps older than the newest.
	int modelCoeffs[$];
	int modelHistory[$];

	logic [31:0] lfsrState;
	int valueErrors;
	int otherErrors;
	int cycleCount;
	int timeoutLimit;
	bit verdictGiven;

	firFilter i_firFilter (.*);

	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	// The limit is set at time zero, once the table is known.
	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount > timeoutLimit) begin
			verdictGiven = 1'b1;
			$display("Timeout: the run did not finish within %0d cycles.", timeoutLimit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// The bound checker can end the run early, and such a run has failed.
	final begin
		if (!verdictGiven) begin
			$display("*** TEST FAILED ***");
		end
	end

	// Inputs change 5 units after the edge, and outputs are read there too.
	task automatic nextCycle();
		@(posedge clock);
		#5;
	endtask

	task automatic addRow(input rowOp op, input int value, input bit expectOut,
			input string name);
		rowOps.push_back(op);
		rowValues.push_back(value);
		rowExpects.push_back(expectOut);
		rowNames.push_back(name);
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One signed 8-bit sample, one LFSR step per bit.
	function automatic int randomSample();
		logic [7:0] bits;
		bits = '0;
		for (int i = 0; i < 8; i++) begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[6:0], lfsrState[0]};
		end
		return int'($signed(bits));
	endfunction

	// y = sum of h[k] * x[t-k]; missing history counts as zero.
	function automatic int modelOutput();
		int sum;
		sum = 0;
		for (int k = 0; k < NumTaps; k++) begin
			if (k < modelCoeffs.size() && k < modelHistory.size()) begin
				sum += modelCoeffs[k] * modelHistory[k];
			end
		end
		return sum;
	endfunction

	task automatic applyReset(input string name);
		rst = 1'b1;
		repeat (2) begin
			nextCycle();
		end
		rst = 1'b0;
		modelCoeffs.delete();
		modelHistory.delete();
		assert (!outValid && !busy && !coefficientsReady) else begin
			otherErrors++;
			$display("%s: a control output was high right after reset.", name);
		end
		assert (dataOut == '0) else begin
			valueErrors++;
			$display("ERROR %s: dataOut expected 0 actual %0d", name, dataOut);
		end
	endtask

	// Only the first NumTaps coefficients after reset count.
	task automatic loadCoeff(input int value, input string name);
		bit expectReady;
		coefficientStrobe = 1'b1;
		coefficientIn = coeffWord'(value);
		nextCycle();
		coefficientStrobe = 1'b0;
		if (modelCoeffs.size() < NumTaps) begin
			modelCoeffs.push_back(value);
		end
		expectReady = (modelCoeffs.size() == NumTaps);
		assert (coefficientsReady == expectReady) else begin
			valueErrors++;
			$display("ERROR %s: coefficientsReady expected %0d actual %0d", name,
				expectReady, coefficientsReady);
		end
	endtask

	// No result may appear, busy stays low and dataOut holds its value.
	task automatic watchQuiet(input int cycles, input string name);
		accWord heldOut;
		heldOut = dataOut;
		repeat (cycles) begin
			nextCycle();
			assert (!outValid && !busy) else begin
				otherErrors++;
				$display("%s: outValid or busy went high when no result was due.", name);
			end
		end
		assert (dataOut == heldOut) else begin
			valueErrors++;
			$display("ERROR %s: dataOut expected %0d actual %0d", name, heldOut, dataOut);
		end
	endtask

	task automatic runSample(input int value, input bit expectOut, input bit dropSecond,
			input string name);
		int cycles;
		int expected;
		dataStrobe = 1'b1;
		dataIn = sampleWord'(value);
		nextCycle();
		dataStrobe = 1'b0;
		// The edge that took the strobe is cycle zero.
		cycles = 0;
		if (expectOut) begin
			modelHistory.push_front(value);
			if (modelHistory.size() > NumTaps) begin
				void'(modelHistory.pop_back());
			end
			expected = modelOutput();
			while (!outValid && cycles < NumTaps + 4) begin
				// A result is pending, so further strobes would be dropped.
				assert (busy) else begin
					otherErrors++;
					$display("%s: busy was low while a result was pending.", name);
				end
				// This strobe arrives while busy and is lost.
				if (dropSecond && cycles == 2) begin
					dataStrobe = 1'b1;
					dataIn = sampleWord'(value + 37);
				end
				nextCycle();
				dataStrobe = 1'b0;
				cycles++;
			end
			assert (outValid) else begin
				otherErrors++;
				$display("%s: no outValid within %0d cycles of the strobe.", name, cycles);
			end
			assert (cycles == NumTaps + 2) else begin
				valueErrors++;
				$display("ERROR %s: latency expected %0d actual %0d", name, NumTaps + 2,
					cycles);
			end
			assert (int'(dataOut) == expected) else begin
				valueErrors++;
				$display("ERROR %s: dataOut expected %0d actual %0d", name, expected, dataOut);
			end
		end
		if (!expectOut || dropSecond) begin
			watchQuiet(NumTaps + 4, name);
		end
	endtask

	task automatic buildTable();
		int h[NumTaps] = '{3, -7, 12, 25, -40, 9, -2, 64};
		addRow(opSample, 5, 1'b0, "strobeBeforeLoad");
		for (int k = 0; k < NumTaps; k++) begin
			addRow(opCoeff, h[k], 1'b0, $sformatf("loadCoeff%0d", k));
		end
		addRow(opCoeff, 99, 1'b0, "ignoredNinthCoeff");
		for (int k = 0; k < NumTaps; k++) begin
			addRow(opSample, (k == 0) ? 1 : 0, 1'b1, $sformatf("impulse%0d", k));
		end
		for (int k = 0; k < 6; k++) begin
			addRow(opSample, randomSample(), 1'b1, $sformatf("random%0d", k));
		end
		addRow(opDouble, randomSample(), 1'b1, "droppedStrobe");
		// The dropped sample must not show up in the next result.
		addRow(opSample, randomSample(), 1'b1, "afterDrop");
		addRow(opReset, 0, 1'b0, "reloadReset");
		for (int k = 0; k < NumTaps; k++) begin
			addRow(opCoeff, -128, 1'b0, $sformatf("minCoeff%0d", k));
		end
		// The last of these sums eight products of 16384, giving 131072.
		for (int k = 0; k < NumTaps; k++) begin
			addRow(opSample, -128, 1'b1, $sformatf("fullScale%0d", k));
		end
		addRow(opStop, 0, 1'b0, "stopPulse");
		addRow(opSample, 17, 1'b0, "afterStop0");
		addRow(opSample, -3, 1'b0, "afterStop1");
		addRow(opWait, 4, 1'b0, "finalWait");
	endtask

	initial begin
		rst = 1'b1;
		coefficientStrobe = 1'b0;
		coefficientIn = '0;
		dataStrobe = 1'b0;
		dataIn = '0;
		stop = 1'b0;
		valueErrors = 0;
		otherErrors = 0;
		cycleCount = 0;
		verdictGiven = 1'b0;
		lfsrState = 32'hfbde_3f3e;
		buildTable();
		timeoutLimit = rowOps.size() * (NumTaps + 4) + 50;
		applyReset("initialReset");
		for (int r = 0; r < rowOps.size(); r++) begin
			case (rowOps[r])
				opCoeff: loadCoeff(rowValues[r], rowNames[r]);
				opSample: runSample(rowValues[r], rowExpects[r], 1'b0, rowNames[r]);
				opDouble: runSample(rowValues[r], rowExpects[r], 1'b1, rowNames[r]);
				opStop: begin
					stop = 1'b1;
					nextCycle();
					stop = 1'b0;
				end
				opReset: applyReset(rowNames[r]);
				default: watchQuiet(rowValues[r], rowNames[r]);
			endcase
		end
		verdictGiven = 1'b1;
		$display("Closing count: %0d value errors, %0d other errors.", valueErrors,
			otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* sim/firFilter_chk.sv */
/*
 * Protocol checker for the FIR filter, bound to the top level.
 */
module firFilterChk (
	input logic clock,
	input logic rst,
	input logic outValid,
	input logic busy,
	input logic coefficientsReady
);

	// A result is announced for exactly one cycle.
	assert property (@(posedge clock) disable iff (rst) outValid |=> !outValid)
		else $error("outValid stayed high for two cycles in a row");

	// The engine cannot start a run before the coefficient bank is full.
	assert property (@(posedge clock) disable iff (rst) $rose(busy) |-> coefficientsReady)
		else $error("busy rose while coefficientsReady was low");

	// busy falls in the same cycle that the result is published.
	assert property (@(posedge clock) disable iff (rst) outValid |-> !busy)
		else $error("busy was still high while outValid was high");

endmodule

bind firFilter firFilterChk i_firFilterChk (
	.clock(clock),
	.rst(rst),
	.outValid(outValid),
	.busy(busy),
	.coefficientsReady(coefficientsReady)
);
